/* flist.f */
src/iagc_status_pkg.sv
src/iagc_bus_pkg.sv
src/iagc_control.sv
src/phase_detector.sv
src/pmod_unit.sv
src/iagc_top.sv
testbench/tb_iagc_top.sv

/* src/iagc_bus_pkg.sv */
`default_nettype none

package iagc_bus_pkg;

    localparam int WB_DATA_WIDTH = 32;
    localparam int WB_ADDR_WIDTH = 2;

    // register map.
    localparam logic [WB_ADDR_WIDTH-1:0] ADDR_COMMAND = 2'd0;
    localparam logic [WB_ADDR_WIDTH-1:0] ADDR_STATUS  = 2'd1;
    localparam logic [WB_ADDR_WIDTH-1:0] ADDR_DUMP    = 2'd2;

    localparam int SAMPLE_WIDTH  = 12;
    localparam int PATTERN_WIDTH = 16;
    localparam int DEC_WIDTH     = 8;
    localparam int COUNT_WIDTH   = 16;
    localparam int INDEX_WIDTH   = $clog2(PATTERN_WIDTH);

    localparam int CMD_WIDTH = 4;

    localparam logic [CMD_WIDTH-1:0] CMD_START     = 4'd1;
    localparam logic [CMD_WIDTH-1:0] CMD_STOP      = 4'd2;
    localparam logic [CMD_WIDTH-1:0] CMD_DUMP_REF  = 4'd3;
    localparam logic [CMD_WIDTH-1:0] CMD_DUMP_ERR  = 4'd4;
    localparam logic [CMD_WIDTH-1:0] CMD_CLEAN_MEM = 4'd5;
    localparam logic [CMD_WIDTH-1:0] CMD_SET_MEM   = 4'd6;
    localparam logic [CMD_WIDTH-1:0] CMD_SET_DEC   = 4'd7;
    localparam logic [CMD_WIDTH-1:0] CMD_HALT      = 4'd8;

endpackage

`default_nettype wire

/* src/iagc_control.sv */
`default_nettype none

module iagc_control
    import iagc_status_pkg::*, iagc_bus_pkg::*;
(
    input  wire                       i_clock,
    input  wire                       i_reset,
    input  wire                       i_wb_cyc,
    input  wire                       i_wb_stb,
    input  wire                       i_wb_we,
    input  wire  [WB_ADDR_WIDTH-1:0]  i_wb_adr,
    input  wire  [WB_DATA_WIDTH-1:0]  i_wb_dat,
    input  wire  [PATTERN_WIDTH-1:0]  i_pattern,
    input  wire  [COUNT_WIDTH-1:0]    i_err_count,
    output logic                      o_wb_ack,
    output logic [WB_DATA_WIDTH-1:0]  o_wb_dat,
    output logic [STATUS_WIDTH-1:0]   o_status,
    output logic                      o_enable,
    output logic                      o_clean,
    output logic                      o_load_pattern,
    output logic                      o_load_dec,
    output logic [PATTERN_WIDTH-1:0]  o_arg
);

    logic [STATUS_WIDTH-1:0]  status;
    logic [TIMER_WIDTH-1:0]   timer;
    logic [CMD_WIDTH-1:0]     cmd;
    logic [PATTERN_WIDTH-1:0] arg;
    logic [WB_DATA_WIDTH-1:0] dump;
    logic                     bus_req;
    logic                     cmd_write;
    logic                     init_first;

    assign bus_req    = i_wb_cyc & i_wb_stb;
    assign cmd_write  = o_wb_ack & bus_req & i_wb_we & (i_wb_adr == ADDR_COMMAND);
    assign init_first = (status == IAGC_STATUS_INIT) && (timer == '0);

    // single-cycle ack, one cycle after the request is seen.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= bus_req & ~o_wb_ack;
        end
    end

    // read data is ready together with ack.
    always_ff @(posedge i_clock) begin
        if (bus_req & ~o_wb_ack) begin
            case (i_wb_adr)
                ADDR_COMMAND: o_wb_dat <= {arg, {(WB_DATA_WIDTH-PATTERN_WIDTH-CMD_WIDTH){1'b0}}, cmd};
                ADDR_STATUS:  o_wb_dat <= WB_DATA_WIDTH'(status);
                ADDR_DUMP:    o_wb_dat <= dump;
                default:      o_wb_dat <= '0;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (status == IAGC_STATUS_DUMP_REF) begin
            dump <= WB_DATA_WIDTH'(i_pattern);
        end else if (status == IAGC_STATUS_DUMP_ERR) begin
            dump <= WB_DATA_WIDTH'(i_err_count);
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            status <= IAGC_STATUS_RESET;
            timer  <= '0;
            cmd    <= '0;
            arg    <= '0;
        end else begin
            case (status)
                IAGC_STATUS_RESET: begin
                    status <= IAGC_STATUS_INIT;
                    timer  <= '0;
                end
                IAGC_STATUS_INIT: begin
                    if (timer == TIMER_WIDTH'(INIT_TICKS - 1)) begin
                        status <= IAGC_STATUS_IDLE;
                    end
                    timer <= timer + 1'b1;
                end
                IAGC_STATUS_IDLE, IAGC_STATUS_SAMPLE: begin
                    if (cmd_write) begin  // other states drop the write.
                        cmd    <= i_wb_dat[CMD_WIDTH-1:0];
                        arg    <= i_wb_dat[WB_DATA_WIDTH-1 -: PATTERN_WIDTH];
                        status <= IAGC_STATUS_CMD_PARSE;
                    end
                end
                IAGC_STATUS_CMD_PARSE: begin
                    timer <= '0;
                    case (cmd)
                        CMD_START:     status <= IAGC_STATUS_SAMPLE;
                        CMD_STOP:      status <= IAGC_STATUS_IDLE;
                        CMD_DUMP_REF:  status <= IAGC_STATUS_DUMP_REF;
                        CMD_DUMP_ERR:  status <= IAGC_STATUS_DUMP_ERR;
                        CMD_CLEAN_MEM: status <= IAGC_STATUS_CLEAN_MEM;
                        CMD_SET_MEM:   status <= IAGC_STATUS_SET_MEM;
                        CMD_SET_DEC:   status <= IAGC_STATUS_SET_DEC;
                        CMD_HALT:      status <= IAGC_STATUS_HALT;
                        default:       status <= IAGC_STATUS_CMD_ERROR;
                    endcase
                end
                IAGC_STATUS_CMD_ERROR: begin
                    if (timer == TIMER_WIDTH'(ERROR_HOLD_TICKS - 1)) begin
                        status <= IAGC_STATUS_IDLE;
                    end
                    timer <= timer + 1'b1;
                end
                IAGC_STATUS_HALT: begin
                    status <= IAGC_STATUS_HALT;  // only reset leaves.
                end
                default: begin
                    status <= IAGC_STATUS_IDLE;
                end
            endcase
        end
    end

    // init clears the pattern and loads a decimation of one.
    assign o_status       = status;
    assign o_enable       = (status == IAGC_STATUS_SAMPLE);
    assign o_clean        = (status == IAGC_STATUS_CLEAN_MEM) || init_first;
    assign o_load_pattern = (status == IAGC_STATUS_SET_MEM);
    assign o_load_dec     = (status == IAGC_STATUS_SET_DEC) || init_first;
    assign o_arg          = (status == IAGC_STATUS_INIT) ? PATTERN_WIDTH'(1) : arg;

endmodule

`default_nettype wire

/* src/iagc_status_pkg.sv */
`default_nettype none

package iagc_status_pkg;

    localparam int STATUS_WIDTH = 4;

    // status codes, in the order the LED unit expects.
    localparam logic [STATUS_WIDTH-1:0] IAGC_STATUS_RESET     = 4'd0;
    localparam logic [STATUS_WIDTH-1:0] IAGC_STATUS_INIT      = 4'd1;
    localparam logic [STATUS_WIDTH-1:0] IAGC_STATUS_IDLE      = 4'd2;
    localparam logic [STATUS_WIDTH-1:0] IAGC_STATUS_SAMPLE    = 4'd3;
    localparam logic [STATUS_WIDTH-1:0] IAGC_STATUS_CMD_PARSE = 4'd4;
    localparam logic [STATUS_WIDTH-1:0] IAGC_STATUS_CMD_READ  = 4'd5;
    localparam logic [STATUS_WIDTH-1:0] IAGC_STATUS_CMD_ERROR = 4'd6;
    localparam logic [STATUS_WIDTH-1:0] IAGC_STATUS_DUMP_REF  = 4'd7;
    localparam logic [STATUS_WIDTH-1:0] IAGC_STATUS_DUMP_ERR  = 4'd8;
    localparam logic [STATUS_WIDTH-1:0] IAGC_STATUS_CLEAN_MEM = 4'd9;
    localparam logic [STATUS_WIDTH-1:0] IAGC_STATUS_SET_MEM   = 4'd10;
    localparam logic [STATUS_WIDTH-1:0] IAGC_STATUS_SET_DEC   = 4'd11;
    localparam logic [STATUS_WIDTH-1:0] IAGC_STATUS_HALT      = 4'd12;

    localparam int LED_PWM_TICKS    = 50;   // pulse period minus one.
    localparam int INIT_TICKS       = 16;
    localparam int ERROR_HOLD_TICKS = 200;  // scaled down for simulation.

    localparam int PWM_COUNT_WIDTH = $clog2(LED_PWM_TICKS + 1);
    localparam int TIMER_WIDTH     = $clog2(ERROR_HOLD_TICKS + 1);

endpackage

`default_nettype wire

/* src/iagc_top.sv */
`default_nettype none

module iagc_top
    import iagc_status_pkg::*, iagc_bus_pkg::*;
(
    input  wire                       i_clock,
    input  wire                       i_reset,
    input  wire                       i_wb_cyc,
    input  wire                       i_wb_stb,
    input  wire                       i_wb_we,
    input  wire  [WB_ADDR_WIDTH-1:0]  i_wb_adr,
    input  wire  [WB_DATA_WIDTH-1:0]  i_wb_dat,
    output wire                       o_wb_ack,
    output wire  [WB_DATA_WIDTH-1:0]  o_wb_dat,
    input  wire                       i_sample_valid,
    input  wire  [SAMPLE_WIDTH-1:0]   i_sample,
    output wire                       o_led0_r,
    output wire                       o_led0_g,
    output wire                       o_led0_b,
    output wire                       o_led1_r,
    output wire                       o_led1_g,
    output wire                       o_led1_b
);

    wire [STATUS_WIDTH-1:0]  status;
    wire                     enable;
    wire                     clean;
    wire                     load_pattern;
    wire                     load_dec;
    wire [PATTERN_WIDTH-1:0] arg;
    wire [PATTERN_WIDTH-1:0] pattern;
    wire [COUNT_WIDTH-1:0]   err_count;
    wire                     in_phase;

    iagc_control u_control (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_wb_cyc       (i_wb_cyc),
        .i_wb_stb       (i_wb_stb),
        .i_wb_we        (i_wb_we),
        .i_wb_adr       (i_wb_adr),
        .i_wb_dat       (i_wb_dat),
        .i_pattern      (pattern),
        .i_err_count    (err_count),
        .o_wb_ack       (o_wb_ack),
        .o_wb_dat       (o_wb_dat),
        .o_status       (status),
        .o_enable       (enable),
        .o_clean        (clean),
        .o_load_pattern (load_pattern),
        .o_load_dec     (load_dec),
        .o_arg          (arg)
    );

    phase_detector u_detector (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_enable       (enable),
        .i_clean        (clean),
        .i_load_pattern (load_pattern),
        .i_load_dec     (load_dec),
        .i_arg          (arg),
        .i_sample_valid (i_sample_valid),
        .i_sample       (i_sample),
        .o_pattern      (pattern),
        .o_err_count    (err_count),
        .o_in_phase     (in_phase)
    );

    pmod_unit u_pmod (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_iagc_status  (status),
        .i_in_phase     (in_phase),
        .o_led0_r       (o_led0_r),
        .o_led0_g       (o_led0_g),
        .o_led0_b       (o_led0_b),
        .o_led1_r       (o_led1_r),
        .o_led1_g       (o_led1_g),
        .o_led1_b       (o_led1_b)
    );

endmodule

`default_nettype wire

/* src/phase_detector.sv */
`default_nettype none

module phase_detector
    import iagc_bus_pkg::*;
(
    input  wire                       i_clock,
    input  wire                       i_reset,
    input  wire                       i_enable,
    input  wire                       i_clean,
    input  wire                       i_load_pattern,
    input  wire                       i_load_dec,
    input  wire  [PATTERN_WIDTH-1:0]  i_arg,
    input  wire                       i_sample_valid,
    input  wire  [SAMPLE_WIDTH-1:0]   i_sample,
    output logic [PATTERN_WIDTH-1:0]  o_pattern,
    output logic [COUNT_WIDTH-1:0]    o_err_count,
    output logic                      o_in_phase
);

    logic [DEC_WIDTH-1:0]   dec;
    logic [DEC_WIDTH-1:0]   dec_count;
    logic [INDEX_WIDTH-1:0] bit_index;
    logic                   keep;
    logic                   mismatch;

    // a decimation of zero behaves as one.
    assign keep     = i_enable & i_sample_valid &
                      ((dec == '0) || (dec_count == dec - DEC_WIDTH'(1)));
    assign mismatch = i_sample[SAMPLE_WIDTH-1] ^ o_pattern[bit_index];

    always_ff @(posedge i_clock) begin
        if (i_clean) begin
            o_pattern <= '0;
        end else if (i_load_pattern) begin
            o_pattern <= i_arg;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            dec <= DEC_WIDTH'(1);
        end else if (i_load_dec) begin
            dec <= i_arg[DEC_WIDTH-1:0];
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            dec_count   <= '0;
            bit_index   <= '0;
            o_err_count <= '0;
            o_in_phase  <= 1'b0;
        end else if (i_clean || i_load_pattern || i_load_dec) begin
            bit_index <= '0;
            if (i_clean) begin
                o_err_count <= '0;
                o_in_phase  <= 1'b0;
            end
            if (i_load_pattern || i_load_dec) begin
                dec_count <= '0;
            end
        end else if (i_enable && i_sample_valid) begin
            if (keep) begin
                dec_count  <= '0;
                o_in_phase <= ~mismatch;
                if (mismatch && (o_err_count != '1)) begin
                    o_err_count <= o_err_count + 1'b1;  // saturates.
                end
                bit_index <= (bit_index == INDEX_WIDTH'(PATTERN_WIDTH - 1)) ?
                             '0 : bit_index + 1'b1;
            end else begin
                dec_count <= dec_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/pmod_unit.sv */
`default_nettype none

module pmod_unit
    import iagc_status_pkg::*;
(
    input  wire                      i_clock,
    input  wire                      i_reset,
    input  wire  [STATUS_WIDTH-1:0]  i_iagc_status,
    input  wire                      i_in_phase,
    output logic                     o_led0_r,
    output logic                     o_led0_g,
    output logic                     o_led0_b,
    output logic                     o_led1_r,
    output logic                     o_led1_g,
    output logic                     o_led1_b
);

    logic [PWM_COUNT_WIDTH-1:0] pwm_count;
    logic                       led_pwm;

    // one pulse cycle in every LED_PWM_TICKS+1.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            pwm_count <= '0;
            led_pwm   <= 1'b0;
        end else if (pwm_count == PWM_COUNT_WIDTH'(LED_PWM_TICKS)) begin
            pwm_count <= '0;
            led_pwm   <= 1'b1;
        end else begin
            pwm_count <= pwm_count + 1'b1;
            led_pwm   <= 1'b0;
        end
    end

    always_comb begin
        o_led0_r = 1'b0;
        o_led0_g = 1'b0;
        o_led0_b = 1'b0;
        case (i_iagc_status)
            IAGC_STATUS_INIT:      o_led0_r = led_pwm;
            IAGC_STATUS_IDLE:      o_led0_g = led_pwm;
            IAGC_STATUS_SAMPLE:    o_led0_b = led_pwm;
            IAGC_STATUS_CMD_ERROR: o_led0_r = led_pwm;
            IAGC_STATUS_DUMP_REF, IAGC_STATUS_DUMP_ERR: begin
                o_led0_r = led_pwm;  // yellow.
                o_led0_g = led_pwm;
            end
            default: begin
                o_led0_r = 1'b0;
            end
        endcase
    end

    // second LED shows the last comparison.
    always_comb begin
        o_led1_r = i_in_phase ? 1'b0 : led_pwm;
        o_led1_g = i_in_phase ? led_pwm : 1'b0;
        o_led1_b = 1'b0;
    end

endmodule

`default_nettype wire

/* testbench/tb_iagc_top.sv */
`default_nettype none

module tb_iagc_top
    import iagc_status_pkg::*, iagc_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_SAMPLES = 300;
    localparam int PERIOD      = LED_PWM_TICKS + 1;
    localparam int TEST_CYCLES = 5 + INIT_TICKS + 2 + 13 * PERIOD + 20 * 8 +
                                 NUM_SAMPLES * 4 + ERROR_HOLD_TICKS;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
    localparam logic [CMD_WIDTH-1:0] BAD_CMD = 4'hF;

    logic                     i_clock = 1'b0;
    logic                     i_reset;
    logic                     i_wb_cyc;
    logic                     i_wb_stb;
    logic                     i_wb_we;
    logic [WB_ADDR_WIDTH-1:0] i_wb_adr;
    logic [WB_DATA_WIDTH-1:0] i_wb_dat;
    logic                     i_sample_valid;
    logic [SAMPLE_WIDTH-1:0]  i_sample;
    wire                      o_wb_ack;
    wire  [WB_DATA_WIDTH-1:0] o_wb_dat;
    wire                      o_led0_r;
    wire                      o_led0_g;
    wire                      o_led0_b;
    wire                      o_led1_r;
    wire                      o_led1_g;
    wire                      o_led1_b;

    logic [15:0] lfsr_state = 16'd41;
    logic        sign_log [NUM_SAMPLES];
    int          cycle_count = 0;
    int          led0_r_count;
    int          led0_g_count;
    int          led0_b_count;
    int          led1_r_count;
    int          led1_g_count;
    int          led1_b_count;

    iagc_top i_dut (.*);

    always #20 i_clock = ~i_clock;

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    // leds are sampled mid cycle.
    always @(negedge i_clock) begin
        led0_r_count += int'(o_led0_r);
        led0_g_count += int'(o_led0_g);
        led0_b_count += int'(o_led0_b);
        led1_r_count += int'(o_led1_r);
        led1_g_count += int'(o_led1_g);
        led1_b_count += int'(o_led1_b);
    end

    // galois lfsr, one step per bit.
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        int          k;
        value = '0;
        for (k = 0; k < n; k++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    // returns {last match, mismatch count} over the logged sign bits.
    function automatic logic [COUNT_WIDTH:0] expected_phase(input logic [15:0] pattern,
                                                            input int dec, input int n);
        int                     step;
        int                     idx;
        int                     skip;
        int                     i;
        logic [COUNT_WIDTH-1:0] count;
        logic                   match;
        step  = (dec == 0) ? 1 : dec;
        idx   = 0;
        skip  = 0;
        count = '0;
        match = 1'b0;
        for (i = 0; i < n; i++) begin
            if (skip == step - 1) begin
                skip  = 0;
                match = (sign_log[i] == pattern[idx]);
                if (!match && count != '1) count++;
                idx = (idx + 1) % PATTERN_WIDTH;
            end else begin
                skip++;
            end
        end
        return {match, count};
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s: got %0h, expected %0h", $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic write_reg(input logic [WB_ADDR_WIDTH-1:0] adr,
                             input logic [WB_DATA_WIDTH-1:0] data);
        i_wb_cyc <= 1'b1;
        i_wb_stb <= 1'b1;
        i_wb_we  <= 1'b1;
        i_wb_adr <= adr;
        i_wb_dat <= data;
        do @(negedge i_clock); while (!o_wb_ack);
        @(posedge i_clock);
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
        i_wb_we  <= 1'b0;
        repeat (2) @(posedge i_clock);  // parse plus target state.
    endtask

    task automatic read_reg(input logic [WB_ADDR_WIDTH-1:0] adr,
                            output logic [WB_DATA_WIDTH-1:0] data);
        i_wb_cyc <= 1'b1;
        i_wb_stb <= 1'b1;
        i_wb_we  <= 1'b0;
        i_wb_adr <= adr;
        do @(negedge i_clock); while (!o_wb_ack);
        data = o_wb_dat;
        @(posedge i_clock);
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
    endtask

    task automatic send_command(input logic [CMD_WIDTH-1:0] cmd, input logic [15:0] arg);
        write_reg(ADDR_COMMAND, {arg, 12'd0, cmd});
    endtask

    task automatic clear_led_counts();
        led0_r_count = 0;
        led0_g_count = 0;
        led0_b_count = 0;
        led1_r_count = 0;
        led1_g_count = 0;
        led1_b_count = 0;
    endtask

    initial begin
        logic [31:0] data;
        logic [15:0] pattern;
        logic [16:0] expected;
        logic [11:0] sample;
        int          n;
        int          gap;
        i_reset        <= 1'b1;
        i_wb_cyc       <= 1'b0;
        i_wb_stb       <= 1'b0;
        i_wb_we        <= 1'b0;
        i_wb_adr       <= '0;
        i_wb_dat       <= '0;
        i_sample_valid <= 1'b0;
        i_sample       <= '0;
        repeat (5) @(posedge i_clock);
        i_reset <= 1'b0;

        // reset and idle.
        repeat (INIT_TICKS + 2) @(posedge i_clock);
        read_reg(ADDR_STATUS, data);
        check_value("status after init", data, IAGC_STATUS_IDLE);
        clear_led_counts();
        repeat (10 * PERIOD) @(posedge i_clock);
        check_value("idle led0 green pulses", led0_g_count, 10);
        check_value("idle led0 red pulses", led0_r_count, 0);
        check_value("idle led0 blue pulses", led0_b_count, 0);
        check_value("idle led1 red pulses", led1_r_count, 10);
        check_value("idle led1 green pulses", led1_g_count, 0);
        check_value("idle led1 blue pulses", led1_b_count, 0);

        // pattern memory.
        pattern = 16'(random_bits(16));
        send_command(CMD_SET_MEM, pattern);
        send_command(CMD_DUMP_REF, '0);
        read_reg(ADDR_DUMP, data);
        check_value("dumped pattern", data, {16'd0, pattern});
        send_command(CMD_CLEAN_MEM, '0);
        send_command(CMD_DUMP_REF, '0);
        read_reg(ADDR_DUMP, data);
        check_value("pattern after clean", data, 0);

        // phase detection with decimation of three.
        pattern = 16'(random_bits(16));
        send_command(CMD_SET_MEM, pattern);
        send_command(CMD_SET_DEC, 16'd3);
        send_command(CMD_START, '0);
        clear_led_counts();
        for (n = 0; n < NUM_SAMPLES; n++) begin
            gap = random_bits(2);
            i_sample_valid <= 1'b0;
            repeat (gap) @(posedge i_clock);
            sample = SAMPLE_WIDTH'(random_bits(SAMPLE_WIDTH));
            i_sample_valid <= 1'b1;
            i_sample       <= sample;
            sign_log[n] = sample[SAMPLE_WIDTH-1];
            @(posedge i_clock);
        end
        i_sample_valid <= 1'b0;
        check_value("sample led0 red pulses", led0_r_count, 0);
        check_value("sample led0 green pulses", led0_g_count, 0);
        check_value("sample led0 blue seen", led0_b_count > 0, 1);
        send_command(CMD_STOP, '0);
        send_command(CMD_DUMP_ERR, '0);
        read_reg(ADDR_DUMP, data);
        expected = expected_phase(pattern, 3, NUM_SAMPLES);
        check_value("mismatch count", data, {16'd0, expected[15:0]});
        clear_led_counts();
        repeat (PERIOD) @(posedge i_clock);
        check_value("led1 green pulses", led1_g_count, expected[16] ? 1 : 0);
        check_value("led1 red pulses", led1_r_count, expected[16] ? 0 : 1);
        check_value("led1 blue pulses", led1_b_count, 0);

        // unknown command.
        send_command(BAD_CMD, '0);
        read_reg(ADDR_STATUS, data);
        check_value("status after bad command", data, IAGC_STATUS_CMD_ERROR);
        clear_led_counts();
        repeat (PERIOD) @(posedge i_clock);
        check_value("error led0 red pulses", led0_r_count, 1);
        check_value("error led0 green pulses", led0_g_count, 0);
        check_value("error led0 blue pulses", led0_b_count, 0);
        repeat (ERROR_HOLD_TICKS) @(posedge i_clock);
        read_reg(ADDR_STATUS, data);
        check_value("status after error hold", data, IAGC_STATUS_IDLE);

        // halt holds until reset.
        send_command(CMD_HALT, '0);
        read_reg(ADDR_STATUS, data);
        check_value("status after halt", data, IAGC_STATUS_HALT);
        clear_led_counts();
        repeat (PERIOD) @(posedge i_clock);
        check_value("halt led0 pulses", led0_r_count + led0_g_count + led0_b_count, 0);
        send_command(CMD_START, '0);
        read_reg(ADDR_STATUS, data);
        check_value("status after start in halt", data, IAGC_STATUS_HALT);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
